// File: kd_patch_pkg.sv
// Patch geometry for the KD-tree search engine
// Dimension value, patch vector, split select and dimension pick function
`default_nettype none

package kd_patch_pkg;

  localparam int DIM_WIDTH = 11;  // Bits per signed dimension
  localparam int NUM_DIMS  = 5;   // Dimensions per patch

  // One signed coordinate of a patch
  typedef logic signed [DIM_WIDTH-1:0] dim_t;

  // Whole patch of 55 bits
  // Dimension 0 sits in bits 10:0 and dimension 4 in bits 54:44
  typedef dim_t [NUM_DIMS-1:0] patch_t;

  typedef logic [2:0] dim_sel_t;  // Values 5 to 7 select nothing

  // Pull the selected coordinate out of a patch
  // An out of range select reads as zero
  function automatic dim_t select_dim(patch_t patch, dim_sel_t sel);
    dim_t value;
    value = '0;
    case (sel)
      3'd0: value = patch[0];
      3'd1: value = patch[1];
      3'd2: value = patch[2];
      3'd3: value = patch[3];
      3'd4: value = patch[NUM_DIMS-1];  // Top dimension
      default: value = '0;
    endcase
    return value;
  endfunction

endpackage

`default_nettype wire

// File: kd_tree_pkg.sv
// Node configuration types for the KD-tree search engine
// Loader word layout, stored node content, reset values and word conversion
`default_nettype none

package kd_tree_pkg;

  import kd_patch_pkg::*;

  // Word as it arrives from the loader, 22 bits
  typedef struct packed {
    dim_t                 median;     // Bits 21:11
    logic [DIM_WIDTH-1:0] dim_field;  // Bits 10:0
  } cfg_word_t;

  // Content kept per internal node, 14 bits
  typedef struct packed {
    dim_sel_t dim_sel;  // Split dimension
    dim_t     median;   // Signed split threshold
  } node_cfg_t;

  // Invalid dimension held until a node is written
  localparam dim_sel_t RESET_DIM_SEL = 3'd7;

  // Content of a node that was never written
  // Selected value 0 is never below median 0 so such a node always goes right
  localparam node_cfg_t NODE_CFG_RESET = '{
    dim_sel: RESET_DIM_SEL,
    median:  '0
  };

  // Reduce a loader word to the stored node fields
  function automatic node_cfg_t cfg_to_node(cfg_word_t word);
    node_cfg_t node;
    node.dim_sel = word.dim_field[2:0];  // Only 3 low bits carry the dimension
    node.median  = word.median;
    return node;
  endfunction

endpackage

`default_nettype wire

// File: kd_node_table.sv
// Node configuration table for the KD-tree search engine
// Write strobe, wrapping write address, address decode and node registers
`timescale 1ns/1ps
`default_nettype none

module kd_node_table
  import kd_tree_pkg::*;
#(
  parameter int DEPTH = 6  // Tree levels
) (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              cfg_en,      // Config phase level
  input  wire                              cfg_strobe,  // One word per pulse
  input  wire cfg_word_t                   cfg_word,
  output node_cfg_t [2**DEPTH-2:0]         node_cfg     // Heap order, node 0 is root
);

  localparam int NUM_NODES = 2**DEPTH - 1;

  logic                 wr_en;    // Write happens this cycle
  logic [DEPTH-1:0]     wr_addr;  // Heap address of next node to fill
  logic [NUM_NODES-1:0] wr_sel;   // One-hot node select

  // Both enables needed for a write
  assign wr_en = cfg_en & cfg_strobe;

  // Address counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (wr_en) begin
      if (wr_addr == DEPTH'(NUM_NODES - 1)) begin
        wr_addr <= '0;  // Wrap after the last internal node
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // Decode address to a single node
  always_comb begin
    wr_sel = '0;
    if (wr_en) begin
      wr_sel[wr_addr] = 1'b1;
    end
  end

  // Node registers
  // New content shows up on the cycle after the write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_cfg <= {NUM_NODES{NODE_CFG_RESET}};  // Every node invalid until loaded
    end else begin
      for (int n = 0; n < NUM_NODES; n++) begin
        if (wr_sel[n]) begin
          node_cfg[n] <= cfg_to_node(cfg_word);
        end
      end
    end
  end

  // Address stays inside the internal node range across any write sequence
  a_wr_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_addr != DEPTH'(NUM_NODES)
  ) else $error("kd_node_table: write address %0d out of range", wr_addr);

endmodule

`default_nettype wire

// File: kd_tree_level.sv
// One level of the KD-tree search pipeline
// Node compares for both lanes, child steering, patch and hit registers
`timescale 1ns/1ps
`default_nettype none

module kd_tree_level
  import kd_patch_pkg::*, kd_tree_pkg::*;
#(
  parameter int LEVEL = 0,  // Level index, root is 0
  parameter int DEPTH = 6   // Total levels in the tree
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire node_cfg_t [2**LEVEL-1:0]  level_cfg,   // Nodes of this level, left to right
  input  wire patch_t                    in_patch_a,
  input  wire patch_t                    in_patch_b,
  input  wire [2**LEVEL-1:0]             in_hits_a,   // One-hot active node, lane a
  input  wire [2**LEVEL-1:0]             in_hits_b,   // One-hot active node, lane b
  output patch_t                         out_patch_a,
  output patch_t                         out_patch_b,
  output logic [2**(LEVEL+1)-1:0]        out_hits_a,  // Active child, lane a
  output logic [2**(LEVEL+1)-1:0]        out_hits_b   // Active child, lane b
);

  localparam int NODES = 2**LEVEL;

  logic [2*NODES-1:0] child_a;  // Next level hits before the register
  logic [2*NODES-1:0] child_b;

  // Level index must lie inside the tree
  if (LEVEL >= DEPTH) begin : g_bad_level
    $error("kd_tree_level: LEVEL %0d not below DEPTH %0d", LEVEL, DEPTH);
  end

  // Route each active node to its left or right child
  // Left child is bit 2j and right child is bit 2j+1
  function automatic logic [2*NODES-1:0] steer(
    patch_t                  patch,
    logic [NODES-1:0]        hits,
    node_cfg_t [NODES-1:0]   cfg
  );
    logic [2*NODES-1:0] child;
    dim_t               value;
    logic               go_left;
    child = '0;
    for (int j = 0; j < NODES; j++) begin
      value   = select_dim(patch, cfg[j].dim_sel);
      go_left = (value < dim_t'(cfg[j].median));  // Signed, equal goes right
      child[2*j]   = hits[j] & go_left;
      child[2*j+1] = hits[j] & ~go_left;
    end
    return child;
  endfunction

  // Same node set for both lanes
  always_comb begin
    child_a = steer(in_patch_a, in_hits_a, level_cfg);
    child_b = steer(in_patch_b, in_hits_b, level_cfg);
  end

  // Pipeline register, one stage per level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_patch_a <= '0;
      out_patch_b <= '0;
      out_hits_a  <= '0;  // No pair in flight
      out_hits_b  <= '0;
    end else begin
      out_patch_a <= in_patch_a;
      out_patch_b <= in_patch_b;
      out_hits_a  <= child_a;
      out_hits_b  <= child_b;
    end
  end

  // A pair never splits into two paths as it walks down the levels
  a_hits_a_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(out_hits_a)
  ) else $error("kd_tree_level %0d: lane a has several hits", LEVEL);

  a_hits_b_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(out_hits_b)
  ) else $error("kd_tree_level %0d: lane b has several hits", LEVEL);

endmodule

`default_nettype wire

// File: kd_leaf_encoder.sv
// Leaf encoder for the KD-tree search engine
// One-hot to binary leaf numbers for both lanes and the result valid
`timescale 1ns/1ps
`default_nettype none

module kd_leaf_encoder #(
  parameter int DEPTH = 6  // Leaf number width
) (
  input  wire [2**DEPTH-1:0] leaf_hits_a,  // Final one-hot, lane a
  input  wire [2**DEPTH-1:0] leaf_hits_b,  // Final one-hot, lane b
  output logic [DEPTH-1:0]   leaf_a,
  output logic [DEPTH-1:0]   leaf_b,
  output logic               receiver_en   // Both leaves valid this cycle
);

  localparam int LEAVES = 2**DEPTH;

  // OR of the indices of all set bits
  // Gives the bit position for a one-hot input and 0 for an empty one
  function automatic logic [DEPTH-1:0] encode(logic [LEAVES-1:0] hits);
    logic [DEPTH-1:0] index;
    index = '0;
    for (int i = 0; i < LEAVES; i++) begin
      if (hits[i]) begin
        index = index | DEPTH'(i);
      end
    end
    return index;
  endfunction

  always_comb begin
    leaf_a      = encode(leaf_hits_a);
    leaf_b      = encode(leaf_hits_b);
    receiver_en = |leaf_hits_a;  // Lane b travels in step
  end

  // Both lanes enter together so they must leave together
  always_comb begin
    a_lanes_in_step: assert final ((|leaf_hits_a) == (|leaf_hits_b))
      else $error("kd_leaf_encoder: lane a and lane b out of step");
  end

endmodule

`default_nettype wire

// File: kd_tree_search.sv
// Top level of the pipelined KD-tree search engine
// Node table, one pipeline stage per level and the leaf encoder
`timescale 1ns/1ps
`default_nettype none

module kd_tree_search
  import kd_patch_pkg::*, kd_tree_pkg::*;
#(
  parameter int DEPTH = 6  // Levels, also the search latency in cycles
) (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               cfg_en,       // Loader phase
  input  wire               cfg_strobe,   // Word valid
  input  wire cfg_word_t    cfg_word,
  input  wire               patch_en,     // Pair valid
  input  wire patch_t       patch_a,
  input  wire patch_t       patch_b,
  output wire [DEPTH-1:0]   leaf_a,
  output wire [DEPTH-1:0]   leaf_b,
  output wire               receiver_en
);

  localparam int NUM_NODES = 2**DEPTH - 1;
  localparam int HIT_BITS  = 2**(DEPTH+1) - 1;  // Hits of all levels plus leaves

  wire node_cfg_t [NUM_NODES-1:0] node_cfg;  // Heap order

  // Hit vectors laid out in heap order too
  // Level L owns bits 2^L-1 up to 2^(L+1)-2, bit 0 is the entry valid
  wire [HIT_BITS-1:0] hits_a;
  wire [HIT_BITS-1:0] hits_b;

  wire patch_t stage_patch_a [DEPTH];  // Patch at the input of each level
  wire patch_t stage_patch_b [DEPTH];

  assign hits_a[0]        = patch_en;
  assign hits_b[0]        = patch_en;
  assign stage_patch_a[0] = patch_a;
  assign stage_patch_b[0] = patch_b;

  kd_node_table #(
    .DEPTH (DEPTH)
  ) u_node_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_en     (cfg_en),
    .cfg_strobe (cfg_strobe),
    .cfg_word   (cfg_word),
    .node_cfg   (node_cfg)
  );

  for (genvar lvl = 0; lvl < DEPTH; lvl++) begin : g_level
    localparam int IN_LO  = 2**lvl - 1;        // First node of this level
    localparam int OUT_LO = 2**(lvl + 1) - 1;  // First node of the next level

    if (lvl < DEPTH - 1) begin : g_mid
      kd_tree_level #(
        .LEVEL (lvl),
        .DEPTH (DEPTH)
      ) u_level (
        .clk         (clk),
        .rst_n       (rst_n),
        .level_cfg   (node_cfg[2*IN_LO:IN_LO]),
        .in_patch_a  (stage_patch_a[lvl]),
        .in_patch_b  (stage_patch_b[lvl]),
        .in_hits_a   (hits_a[2*IN_LO:IN_LO]),
        .in_hits_b   (hits_b[2*IN_LO:IN_LO]),
        .out_patch_a (stage_patch_a[lvl+1]),
        .out_patch_b (stage_patch_b[lvl+1]),
        .out_hits_a  (hits_a[2*OUT_LO:OUT_LO]),
        .out_hits_b  (hits_b[2*OUT_LO:OUT_LO])
      );
    end else begin : g_last
      // Patches end here, only the leaf hits go on
      kd_tree_level #(
        .LEVEL (lvl),
        .DEPTH (DEPTH)
      ) u_level (
        .clk         (clk),
        .rst_n       (rst_n),
        .level_cfg   (node_cfg[2*IN_LO:IN_LO]),
        .in_patch_a  (stage_patch_a[lvl]),
        .in_patch_b  (stage_patch_b[lvl]),
        .in_hits_a   (hits_a[2*IN_LO:IN_LO]),
        .in_hits_b   (hits_b[2*IN_LO:IN_LO]),
        .out_patch_a (),
        .out_patch_b (),
        .out_hits_a  (hits_a[2*OUT_LO:OUT_LO]),
        .out_hits_b  (hits_b[2*OUT_LO:OUT_LO])
      );
    end
  end

  kd_leaf_encoder #(
    .DEPTH (DEPTH)
  ) u_leaf_encoder (
    .leaf_hits_a (hits_a[HIT_BITS-1:NUM_NODES]),  // Leaf row
    .leaf_hits_b (hits_b[HIT_BITS-1:NUM_NODES]),
    .leaf_a      (leaf_a),
    .leaf_b      (leaf_b),
    .receiver_en (receiver_en)
  );

endmodule

`default_nettype wire

// File: kd_tree_search_tb.sv
// Directed testbench for the KD-tree search engine
// Software tree model, result queue monitor, compare tasks and test tasks
`timescale 1ns/1ps
`default_nettype none

module kd_tree_search_tb
  import kd_patch_pkg::*, kd_tree_pkg::*;
;

  localparam int DEPTH          = 6;
  localparam int NUM_NODES      = 2**DEPTH - 1;
  localparam int TIMEOUT_CYCLES = 3000;  // Tests run for about 420 cycles

  typedef struct packed {
    logic [31:0]      due;     // Negedge count at which the result shows
    logic [DEPTH-1:0] leaf_a;
    logic [DEPTH-1:0] leaf_b;
  } expect_t;

  logic             clk;
  logic             rst_n;
  logic             cfg_en;
  logic             cfg_strobe;
  cfg_word_t        cfg_word;
  logic             patch_en;
  patch_t           patch_a;
  patch_t           patch_b;
  wire  [DEPTH-1:0] leaf_a;
  wire  [DEPTH-1:0] leaf_b;
  wire              receiver_en;

  dim_sel_t    tree_dim [NUM_NODES];  // Model copy of the node table
  dim_t        tree_med [NUM_NODES];
  dim_sel_t    load_dim [NUM_NODES];  // Tree waiting to be loaded
  dim_t        load_med [NUM_NODES];
  int          wr_ptr;                // Model write address
  logic [31:0] rng_state = 32'h9416;
  expect_t     pending [$];           // Results still in the pipeline
  int          neg_count;
  int          cycle_count;

  // Directed tree with the same split on every node of a level
  dim_sel_t lvl_dim [DEPTH] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd0};
  dim_t     lvl_med [DEPTH] = '{11'sd100, -11'sd50, 11'sd0, 11'sd300, -11'sd200, 11'sd101};

  kd_tree_search #(
    .DEPTH (DEPTH)
  ) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_en      (cfg_en),
    .cfg_strobe  (cfg_strobe),
    .cfg_word    (cfg_word),
    .patch_en    (patch_en),
    .patch_a     (patch_a),
    .patch_b     (patch_b),
    .leaf_a      (leaf_a),
    .leaf_b      (leaf_b),
    .receiver_en (receiver_en)
  );

  always #50 clk = ~clk;  // 100 ns period

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_leaf(input string name, input logic [DEPTH-1:0] exp,
                            input logic [DEPTH-1:0] act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  // 32-bit xorshift
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic patch_t rand_patch();
    patch_t      p;
    logic [31:0] r;
    for (int d = 0; d < NUM_DIMS; d++) begin
      r    = next_random();
      p[d] = r[10:0];
    end
    return p;
  endfunction

  function automatic patch_t make_patch(int d0, int d1, int d2, int d3, int d4);
    patch_t p;
    p[0] = dim_t'(d0);
    p[1] = dim_t'(d1);
    p[2] = dim_t'(d2);
    p[3] = dim_t'(d3);
    p[4] = dim_t'(d4);
    return p;
  endfunction

  // Tree walk from the root with one path bit per level and the root bit as MSB
  function automatic logic [DEPTH-1:0] model_leaf(patch_t p);
    int               node;
    logic [DEPTH-1:0] leaf;
    dim_t             value;
    logic             right;
    node = 0;
    leaf = '0;
    for (int lvl = 0; lvl < DEPTH; lvl++) begin
      if (tree_dim[node] < 3'd5) value = p[tree_dim[node]];
      else value = '0;                         // Invalid select reads zero
      right = !(value < tree_med[node]);       // Equal goes right
      leaf  = {leaf[DEPTH-2:0], right};
      node  = 2 * node + 1 + int'(right);
    end
    return leaf;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // One write per cycle and back to back calls keep the strobe high
  task automatic write_node(input dim_sel_t dim, input dim_t med);
    logic [31:0] r;
    r                  = next_random();
    cfg_en             = 1'b1;
    cfg_strobe         = 1'b1;
    cfg_word.median    = med;
    cfg_word.dim_field = {r[7:0], dim};  // Upper bits are junk
    tree_dim[wr_ptr]   = dim;
    tree_med[wr_ptr]   = med;
    wr_ptr             = (wr_ptr == NUM_NODES - 1) ? 0 : wr_ptr + 1;
    next_cycle();
    cfg_strobe = 1'b0;
  endtask

  task automatic load_tree();
    for (int n = 0; n < NUM_NODES; n++) write_node(load_dim[n], load_med[n]);
    cfg_en = 1'b0;
  endtask

  task automatic search_pair(input patch_t a, input patch_t b);
    patch_en = 1'b1;
    patch_a  = a;
    patch_b  = b;
    next_cycle();
    patch_en = 1'b0;
  endtask

  // Waits at negedges for the next result, checks it, then steps past the edge
  task automatic search_expect(input patch_t a, input patch_t b,
                               input logic [DEPTH-1:0] exp_a, input logic [DEPTH-1:0] exp_b);
    int waited;
    search_pair(a, b);
    waited = 0;
    @(negedge clk);
    while (receiver_en !== 1'b1) begin
      waited++;
      if (waited > DEPTH + 2) begin
        $display("No search result %0d cycles after the pair entered", waited);
        stop_with_failure();
      end
      @(negedge clk);
    end
    check_leaf("leaf_a", exp_a, leaf_a);
    check_leaf("leaf_b", exp_b, leaf_b);
    next_cycle();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (pending.size() != 0) begin
      waited++;
      if (waited > DEPTH + 4) begin
        $display("Search results still pending %0d cycles after the last entry", waited);
        stop_with_failure();
      end
      next_cycle();
    end
  endtask

  task automatic after_reset();
    @(negedge clk);
    check_flag("receiver_en", 1'b0, receiver_en);
    check_leaf("leaf_a", '0, leaf_a);
    check_leaf("leaf_b", '0, leaf_b);
    next_cycle();
    search_expect(rand_patch(), rand_patch(), 6'd63, 6'd63);  // Unloaded nodes go right
    drain();
  endtask

  task automatic directed_tree();
    for (int lvl = 0; lvl < DEPTH; lvl++) begin
      for (int j = 0; j < 2**lvl; j++) begin
        load_dim[2**lvl - 1 + j] = lvl_dim[lvl];
        load_med[2**lvl - 1 + j] = lvl_med[lvl];
      end
    end
    load_tree();
    // Equal, just below and just above the medians including negative ones
    search_expect(make_patch(100, -51, 0, 299, -200), make_patch(99, -50, -1, 300, -201),
                  6'd42, 6'd20);
    search_expect(make_patch(99, -50, -1, 300, -201), make_patch(100, -51, 0, 299, -200),
                  6'd20, 6'd42);
    search_expect(make_patch(101, -49, 1, 301, -199), make_patch(101, -49, 1, 301, -199),
                  6'd63, 6'd63);
    drain();
  endtask

  task automatic independent_lanes();
    search_expect(make_patch(101, -49, 1, 301, -199), make_patch(-1024, -1024, -1024, -1024,
                  -1024), 6'd63, 6'd0);
    search_expect(make_patch(-1024, -1024, -1024, -1024, -1024), make_patch(1023, 1023, 1023,
                  1023, 1023), 6'd0, 6'd63);
    drain();
  endtask

  task automatic pipelined_stream();
    for (int i = 0; i < 8; i++) search_pair(rand_patch(), rand_patch());
    next_cycle();  // Two idle cycles
    next_cycle();
    for (int i = 0; i < 3; i++) search_pair(rand_patch(), rand_patch());
    drain();
  endtask

  task automatic random_tree(input int pairs);
    logic [31:0] r;
    for (int n = 0; n < NUM_NODES; n++) begin
      r           = next_random();
      load_dim[n] = dim_sel_t'(r % 32'd5);
      load_med[n] = r[26:16];
    end
    load_tree();
    for (int i = 0; i < pairs; i++) search_pair(rand_patch(), rand_patch());
    drain();
  endtask

  task automatic write_gating();
    for (int i = 0; i < 4; i++) begin
      cfg_en     = 1'b0;  // Strobe alone
      cfg_strobe = 1'b1;
      cfg_word   = cfg_word_t'(next_random());
      next_cycle();
      cfg_strobe = 1'b0;
      next_cycle();
    end
    cfg_en   = 1'b1;  // Enable alone
    cfg_word = cfg_word_t'(next_random());
    repeat (3) next_cycle();
    cfg_en = 1'b0;
    for (int i = 0; i < 10; i++) search_pair(rand_patch(), rand_patch());
    drain();
    random_tree(20);  // Misplaced nodes show if the address moved
  endtask

  // Result queue monitor sampling at the falling edge where outputs are stable
  always @(negedge clk) begin : result_monitor
    expect_t head;
    if (rst_n) begin
      neg_count++;
      if (pending.size() > 0 && pending[0].due == neg_count) begin
        head = pending.pop_front();
        check_flag("receiver_en", 1'b1, receiver_en);
        check_leaf("leaf_a", head.leaf_a, leaf_a);
        check_leaf("leaf_b", head.leaf_b, leaf_b);
      end else begin
        check_flag("receiver_en", 1'b0, receiver_en);
        check_leaf("leaf_a", '0, leaf_a);  // Leaves are 0 when not valid
        check_leaf("leaf_b", '0, leaf_b);
      end
      if (patch_en) begin
        pending.push_back('{due: 32'(neg_count + DEPTH),
                            leaf_a: model_leaf(patch_a), leaf_b: model_leaf(patch_b)});
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycle_count);
      stop_with_failure();
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cfg_en      = 1'b0;
    cfg_strobe  = 1'b0;
    cfg_word    = '0;
    patch_en    = 1'b0;
    patch_a     = '0;
    patch_b     = '0;
    wr_ptr      = 0;
    neg_count   = 0;
    cycle_count = 0;
    for (int n = 0; n < NUM_NODES; n++) begin
      tree_dim[n] = RESET_DIM_SEL;
      tree_med[n] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    after_reset();
    directed_tree();
    independent_lanes();
    pipelined_stream();
    random_tree(100);
    write_gating();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: kd_tree_search.f
kd_patch_pkg.sv
kd_tree_pkg.sv
kd_node_table.sv
kd_tree_level.sv
kd_leaf_encoder.sv
kd_tree_search.sv
kd_tree_search_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the KD-tree search testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal --top-module kd_tree_search_tb \
  -f kd_tree_search.f -Mdir obj_dir -o kd_tree_search_sim > "$LOG" 2>&1 &&
  ./obj_dir/kd_tree_search_sim >> "$LOG" 2>&1 ||
  echo "Build or simulation returned an error" >> "$LOG"

cat "$LOG"

grep -q "^Finished with no errors$" "$LOG" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
